// ==== Makefile ====
# Verilator simulation of the load/store unit testbench
TOP := lsu_tb

sim:
	verilator --binary -Wno-fatal --timescale 1ns/100ps --top-module $(TOP) -f lsu_top.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep "Done: no errors" > /dev/null

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== hw/axi_lite_pkg.sv ====
/*
 * AXI-lite memory bus types
 * response codes, byte strobe and bus word
 */
`include "lsu_macros.svh"

package axi_lite_pkg;

	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} axi_resp_e;

	// one strobe bit per byte lane
	typedef logic [`LSU_DATA_LEN/8-1:0] axi_strb_t;

	typedef logic [`LSU_DATA_LEN-1:0] axi_word_t;

endpackage

// ==== hw/axi_lite_sram.sv ====
/*
 * AXI-lite slave around a word SRAM, one access outstanding
 * byte-merged writes, slverr for indices past the memory depth
 */
`include "lsu_macros.svh"

module axi_lite_sram
	import axi_lite_pkg::*;
(
	input  logic      clk,
	input  logic      rstn,
	input  logic      ar_valid_i,
	output logic      ar_ready_o,
	input  axi_word_t ar_addr_i,
	output logic      r_valid_o,
	input  logic      r_ready_i,
	output axi_word_t r_data_o,
	output axi_resp_e r_resp_o,
	input  logic      aw_valid_i,
	output logic      aw_ready_o,
	input  axi_word_t aw_addr_i,
	input  logic      w_valid_i,
	output logic      w_ready_o,
	input  axi_word_t w_data_i,
	input  axi_strb_t w_strb_i,
	output logic      b_valid_o,
	input  logic      b_ready_i,
	output axi_resp_e b_resp_o
);

	localparam int IDX_LEN = $clog2(`LSU_MEM_WORDS);

	axi_word_t mem [`LSU_MEM_WORDS];
	logic      aw_held, w_held, busy;
	logic      ar_fire, aw_fire, w_fire, wr_go, rd_ok, wr_ok;
	axi_word_t aw_addr_q, w_data_q, wr_addr, wr_data;
	axi_strb_t w_strb_q, wr_strb;

	// readies drop while a response waits
	assign busy = r_valid_o || b_valid_o;
	assign ar_ready_o = !busy && !aw_held && !w_held;
	assign aw_ready_o = !busy && !aw_held;
	assign w_ready_o = !busy && !w_held;

	assign ar_fire = ar_valid_i && ar_ready_o;
	assign aw_fire = aw_valid_i && aw_ready_o;
	assign w_fire = w_valid_i && w_ready_o;

	// a write goes once both address and data are in hand
	assign wr_addr = aw_held ? aw_addr_q : aw_addr_i;
	assign wr_data = w_held ? w_data_q : w_data_i;
	assign wr_strb = w_held ? w_strb_q : w_strb_i;
	assign wr_go = (aw_held || aw_fire) && (w_held || w_fire);

	assign rd_ok = ar_addr_i[`LSU_ADDR_LEN-1:2] < `LSU_MEM_WORDS;
	assign wr_ok = wr_addr[`LSU_ADDR_LEN-1:2] < `LSU_MEM_WORDS;

	always_ff @(posedge clk) begin
		if (rstn) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			r_valid_o <= 1'b0;
			b_valid_o <= 1'b0;
			r_resp_o <= resp_okay;
			b_resp_o <= resp_okay;
		end else begin
			if (r_valid_o && r_ready_i) begin
				r_valid_o <= 1'b0;
			end
			if (b_valid_o && b_ready_i) begin
				b_valid_o <= 1'b0;
			end
			if (ar_fire) begin
				r_valid_o <= 1'b1;
				r_resp_o <= rd_ok ? resp_okay : resp_slverr;
			end
			if (wr_go) begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
				b_valid_o <= 1'b1;
				b_resp_o <= wr_ok ? resp_okay : resp_slverr;
			end else begin
				aw_held <= aw_held || aw_fire;
				w_held <= w_held || w_fire;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rstn) begin
			for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_go && wr_ok) begin
			for (int b = 0; b < `LSU_DATA_LEN / 8; b++) begin
				if (wr_strb[b]) begin
					mem[wr_addr[IDX_LEN+1:2]][8*b +: 8] <= wr_data[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			// zero data on an error read
			r_data_o <= rd_ok ? mem[ar_addr_i[IDX_LEN+1:2]] : '0;
		end
		if (aw_fire) begin
			aw_addr_q <= aw_addr_i;
		end
		if (w_fire) begin
			w_data_q <= w_data_i;
			w_strb_q <= w_strb_i;
		end
	end

endmodule

// ==== hw/delay_lfsr.sv ====
/*
 * free-running Fibonacci LFSR
 * gives pseudo-random handshake delay targets
 */
`include "lsu_macros.svh"

module delay_lfsr #(
	parameter logic [`LSU_LFSR_LEN-1:0] SEED = 'd1
) (
	input  logic                     clk,
	input  logic                     rstn,
	output logic [`LSU_LFSR_LEN-1:0] delay_o
);

	logic feedback;

	// taps for x^4 + x^3 + 1, period 15
	assign feedback = delay_o[`LSU_LFSR_LEN-1] ^ delay_o[`LSU_LFSR_LEN-2];

	always_ff @(posedge clk) begin
		if (rstn) begin
			// seed must be nonzero or the register locks up
			delay_o <= SEED;
		end else begin
			delay_o <= {delay_o[`LSU_LFSR_LEN-2:0], feedback};
		end
	end

endmodule

// ==== hw/load_extend.sv ====
/*
 * load lane selection
 * sign or zero extension of the read word
 */
module load_extend
	import lsu_op_pkg::*, axi_lite_pkg::*;
(
	input  lsu_funct_u funct_i,
	input  logic [1:0] addr_lo_i,
	input  axi_word_t  r_data_i,
	output axi_word_t  load_data_o
);

	logic [7:0]  byte_sel;
	logic [15:0] half_sel;

	assign byte_sel = r_data_i[{addr_lo_i, 3'b000} +: 8];
	assign half_sel = addr_lo_i[1] ? r_data_i[31:16] : r_data_i[15:0];

	always_comb begin
		case (funct_i.load)
			ld_lb: begin
				load_data_o = {{24{byte_sel[7]}}, byte_sel};
			end
			ld_lh: begin
				load_data_o = {{16{half_sel[15]}}, half_sel};
			end
			ld_lbu: begin
				load_data_o = {24'd0, byte_sel};
			end
			ld_lhu: begin
				load_data_o = {16'd0, half_sel};
			end
			default: begin
				// lw and anything else take the full word
				load_data_o = r_data_i;
			end
		endcase
	end

endmodule

// ==== hw/lsu_ctrl.sv ====
/*
 * LSU control FSM: idle, address phase, response phase, done
 * delay counters gate the bus valids and readies
 */
`include "lsu_macros.svh"

module lsu_ctrl
	import lsu_op_pkg::*, axi_lite_pkg::*;
(
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     req_valid_i,
	input  logic                     is_store_i,
	input  lsu_funct_u               funct_i,
	input  axi_word_t                addr_i,
	input  logic                     wd_i,
	input  logic [4:0]               wreg_i,
	input  logic [`LSU_LFSR_LEN-1:0] delay_a_i,
	input  logic [`LSU_LFSR_LEN-1:0] delay_b_i,
	input  axi_word_t                load_data_i,
	input  logic                     ar_ready_i,
	input  logic                     aw_ready_i,
	input  logic                     w_ready_i,
	input  logic                     r_valid_i,
	input  axi_resp_e                r_resp_i,
	input  logic                     b_valid_i,
	input  axi_resp_e                b_resp_i,
	output logic                     done_o,
	output axi_word_t                result_o,
	output logic [4:0]               wreg_o,
	output logic                     wd_o,
	output logic                     err_o,
	output logic                     ar_valid_o,
	output axi_word_t                ar_addr_o,
	output logic                     aw_valid_o,
	output axi_word_t                aw_addr_o,
	output logic                     w_valid_o,
	output logic                     r_ready_o,
	output logic                     b_ready_o,
	output logic                     capture_o
);

	localparam logic [1:0] s_idle = 2'd0;
	localparam logic [1:0] s_addr = 2'd1;
	localparam logic [1:0] s_resp = 2'd2;
	localparam logic [1:0] s_done = 2'd3;

	logic [1:0]               state;
	logic [`LSU_LFSR_LEN-1:0] cnt, tgt_a, tgt_b;
	logic                     aw_sent, w_sent, err_q;
	axi_word_t                addr_q, load_q;
	logic                     is_load, is_wr, a_due, b_due;
	logic                     ar_fire, aw_fire, w_fire, r_fire, b_fire, wr_done;

	// union decode, passthrough when neither view names an access
	assign is_load = !is_store_i && (funct_i.load != ld_none);
	assign is_wr = is_store_i && (funct_i.store.kind != st_none);

	assign a_due = cnt >= tgt_a;
	assign b_due = cnt >= tgt_b;

	assign ar_valid_o = (state == s_addr) && is_load && a_due;
	assign aw_valid_o = (state == s_addr) && is_wr && !aw_sent && a_due;
	assign w_valid_o = (state == s_addr) && is_wr && !w_sent && b_due;
	assign r_ready_o = (state == s_resp) && is_load && a_due;
	assign b_ready_o = (state == s_resp) && is_wr && a_due;

	assign ar_fire = ar_valid_o && ar_ready_i;
	assign aw_fire = aw_valid_o && aw_ready_i;
	assign w_fire = w_valid_o && w_ready_i;
	assign r_fire = r_valid_i && r_ready_o;
	assign b_fire = b_valid_i && b_ready_o;
	// both write channels may finish in different cycles
	assign wr_done = (aw_sent || aw_fire) && (w_sent || w_fire);

	assign capture_o = (state == s_idle) && req_valid_i;
	assign ar_addr_o = addr_q;
	assign aw_addr_o = addr_q;

	assign done_o = (state == s_done);
	assign err_o = done_o && err_q;
	assign result_o = is_load ? load_q : addr_q;
	assign wreg_o = wreg_i;
	// no register writeback after an error response
	assign wd_o = wd_i && !err_q;

	always_ff @(posedge clk) begin
		if (rstn) begin
			state <= s_idle;
			cnt <= '0;
			tgt_a <= '0;
			tgt_b <= '0;
			aw_sent <= 1'b0;
			w_sent <= 1'b0;
			err_q <= 1'b0;
		end else begin
			// saturating phase counter, cleared on each phase entry below
			if (cnt != {`LSU_LFSR_LEN{1'b1}}) begin
				cnt <= cnt + 1'b1;
			end
			case (state)
				s_idle: begin
					if (req_valid_i) begin
						state <= s_addr;
						cnt <= '0;
						tgt_a <= delay_a_i;
						tgt_b <= delay_b_i;
						aw_sent <= 1'b0;
						w_sent <= 1'b0;
						err_q <= 1'b0;
					end
				end
				s_addr: begin
					if (aw_fire) begin
						aw_sent <= 1'b1;
					end
					if (w_fire) begin
						w_sent <= 1'b1;
					end
					if (!is_load && !is_wr) begin
						state <= s_done;
					end else if (ar_fire || (is_wr && wr_done)) begin
						state <= s_resp;
						cnt <= '0;
						tgt_a <= delay_a_i;
					end
				end
				s_resp: begin
					if (r_fire) begin
						err_q <= (r_resp_i != resp_okay);
						state <= s_done;
					end else if (b_fire) begin
						err_q <= (b_resp_i != resp_okay);
						state <= s_done;
					end
				end
				default: begin
					state <= s_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (capture_o) begin
			addr_q <= addr_i;
		end
		if (r_fire) begin
			load_q <= load_data_i;
		end
	end

endmodule

// ==== hw/lsu_macros.svh ====
/*
 * bus and memory widths for the load/store unit
 * plus the delay LFSR width
 */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

`define LSU_DATA_LEN 32
`define LSU_ADDR_LEN 32

// word depth of the on-chip SRAM, higher indices give slverr
`define LSU_MEM_WORDS 256

`define LSU_LFSR_LEN 4

`endif

// ==== hw/lsu_op_pkg.sv ====
/*
 * load and store kind encodings
 * funct union read by the LSU control and datapath
 */
package lsu_op_pkg;

	// load kinds are funct3 + 1 so that zero means no load
	typedef enum logic [2:0] {
		ld_none = 3'd0,
		ld_lb   = 3'd1,
		ld_lh   = 3'd2,
		ld_lw   = 3'd3,
		ld_lbu  = 3'd5,
		ld_lhu  = 3'd6
	} load_kind_e;

	typedef enum logic [1:0] {
		st_none = 2'd0,
		st_sb   = 2'd1,
		st_sh   = 2'd2,
		st_sw   = 2'd3
	} store_kind_e;

	typedef struct packed {
		logic        spare;
		store_kind_e kind;
	} store_view_t;

	// is_store selects which view is meaningful
	typedef union packed {
		load_kind_e  load;
		store_view_t store;
	} lsu_funct_u;

endpackage

// ==== hw/lsu_top.sv ====
/*
 * load/store unit top level
 * control, two delay LFSRs, store and load datapath, SRAM slave
 */
`include "lsu_macros.svh"

module lsu_top
	import lsu_op_pkg::*, axi_lite_pkg::*;
(
	input  logic       clk,
	input  logic       rstn,
	input  logic       req_valid_i,
	input  logic       is_store_i,
	input  lsu_funct_u funct_i,
	input  axi_word_t  addr_i,
	input  axi_word_t  wdata_i,
	input  logic [4:0] wreg_i,
	input  logic       wd_i,
	output logic       done_o,
	output axi_word_t  result_o,
	output logic [4:0] wreg_o,
	output logic       wd_o,
	output logic       err_o
);

	logic [`LSU_LFSR_LEN-1:0] delay_a, delay_b;
	logic                     capture;
	axi_word_t                load_data, ar_addr, aw_addr, r_data, w_data;
	axi_strb_t                w_strb;
	axi_resp_e                r_resp, b_resp;
	logic                     ar_valid, ar_ready, r_valid, r_ready;
	logic                     aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;

	// different seeds keep the two delay streams apart
	delay_lfsr #(.SEED(4'h1)) delay_a_i (
		.clk(clk), .rstn(rstn), .delay_o(delay_a)
	);

	delay_lfsr #(.SEED(4'h9)) delay_b_i (
		.clk(clk), .rstn(rstn), .delay_o(delay_b)
	);

	lsu_ctrl lsu_ctrl_i (
		.clk(clk), .rstn(rstn),
		.req_valid_i(req_valid_i), .is_store_i(is_store_i), .funct_i(funct_i),
		.addr_i(addr_i), .wd_i(wd_i), .wreg_i(wreg_i),
		.delay_a_i(delay_a), .delay_b_i(delay_b), .load_data_i(load_data),
		.ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_addr_o(ar_addr),
		.r_valid_i(r_valid), .r_ready_o(r_ready), .r_resp_i(r_resp),
		.aw_valid_o(aw_valid), .aw_ready_i(aw_ready), .aw_addr_o(aw_addr),
		.w_valid_o(w_valid), .w_ready_i(w_ready),
		.b_valid_i(b_valid), .b_ready_o(b_ready), .b_resp_i(b_resp),
		.done_o(done_o), .result_o(result_o), .wreg_o(wreg_o),
		.wd_o(wd_o), .err_o(err_o), .capture_o(capture)
	);

	store_align store_align_i (
		.clk(clk), .capture_i(capture), .funct_i(funct_i),
		.addr_lo_i(addr_i[1:0]), .wdata_i(wdata_i),
		.w_data_o(w_data), .w_strb_o(w_strb)
	);

	load_extend load_extend_i (
		.funct_i(funct_i), .addr_lo_i(addr_i[1:0]),
		.r_data_i(r_data), .load_data_o(load_data)
	);

	axi_lite_sram axi_lite_sram_i (
		.clk(clk), .rstn(rstn),
		.ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr),
		.r_valid_o(r_valid), .r_ready_i(r_ready), .r_data_o(r_data), .r_resp_o(r_resp),
		.aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_addr_i(aw_addr),
		.w_valid_i(w_valid), .w_ready_o(w_ready), .w_data_i(w_data), .w_strb_i(w_strb),
		.b_valid_o(b_valid), .b_ready_i(b_ready), .b_resp_o(b_resp)
	);

endmodule

// ==== hw/store_align.sv ====
/*
 * store lane alignment
 * write data and byte strobe registered at request acceptance
 */
module store_align
	import lsu_op_pkg::*, axi_lite_pkg::*;
(
	input  logic       clk,
	input  logic       capture_i,
	input  lsu_funct_u funct_i,
	input  logic [1:0] addr_lo_i,
	input  axi_word_t  wdata_i,
	output axi_word_t  w_data_o,
	output axi_strb_t  w_strb_o
);

	axi_word_t lane_data;
	axi_strb_t lane_strb;

	// data copied into every lane, the strobe picks the live ones
	always_comb begin
		case (funct_i.store.kind)
			st_sb: begin
				lane_data = {4{wdata_i[7:0]}};
				lane_strb = 4'b0001 << addr_lo_i;
			end
			st_sh: begin
				lane_data = {2{wdata_i[15:0]}};
				// addr bit 0 ignored for halfwords
				lane_strb = addr_lo_i[1] ? 4'b1100 : 4'b0011;
			end
			st_sw: begin
				lane_data = wdata_i;
				lane_strb = 4'b1111;
			end
			default: begin
				lane_data = wdata_i;
				lane_strb = 4'b0000;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (capture_i) begin
			w_data_o <= lane_data;
			w_strb_o <= lane_strb;
		end
	end

endmodule

// ==== lsu_top.f ====
+incdir+hw
hw/lsu_op_pkg.sv
hw/axi_lite_pkg.sv
hw/delay_lfsr.sv
hw/store_align.sv
hw/load_extend.sv
hw/lsu_ctrl.sv
hw/axi_lite_sram.sv
hw/lsu_top.sv
test/lsu_tb.sv

// ==== test/lsu_tb.sv ====
/*
 * testbench for the load/store unit
 * reads request vectors, drives them with random idle gaps,
 * compares result, error flag and writeback fields
 */
module lsu_tb
	import lsu_op_pkg::*, axi_lite_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int RESET_CYCLES = 8;

	logic       clk;
	logic       rstn;
	logic       req_valid_i;
	logic       is_store_i;
	lsu_funct_u funct_i;
	axi_word_t  addr_i;
	axi_word_t  wdata_i;
	logic [4:0] wreg_i;
	logic       wd_i;
	logic       done_o;
	axi_word_t  result_o;
	logic [4:0] wreg_o;
	logic       wd_o;
	logic       err_o;

	int   errors;
	int   tests;
	int   failed_tests;
	logic timed_out;

	lsu_top lsu_top_i (
		.clk(clk), .rstn(rstn), .req_valid_i(req_valid_i),
		.is_store_i(is_store_i), .funct_i(funct_i), .addr_i(addr_i),
		.wdata_i(wdata_i), .wreg_i(wreg_i), .wd_i(wd_i),
		.done_o(done_o), .result_o(result_o), .wreg_o(wreg_o),
		.wd_o(wd_o), .err_o(err_o)
	);

	always begin
		#5 clk = ~clk;
	end

	task automatic check_word(input string name, input axi_word_t got, input axi_word_t exp);
		if (got !== exp) begin
			$display("error: %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_err(input logic got, input logic exp);
		if (got !== exp) begin
			$display("error: err_o got 0x%h expected 0x%h", got, exp);
			errors++;
		end
	endtask

	task automatic check_wreg(input logic [4:0] got_reg, input logic got_wd,
			input logic [4:0] exp_reg, input logic exp_wd);
		if (got_reg !== exp_reg) begin
			$display("error: wreg_o got 0x%h expected 0x%h", got_reg, exp_reg);
			errors++;
		end
		if (got_wd !== exp_wd) begin
			$display("error: wd_o got 0x%h expected 0x%h", got_wd, exp_wd);
			errors++;
		end
	endtask

	// one request from start pulse to done, inputs held until done
	task automatic run_vector(input int num, input logic st, input lsu_funct_u f,
			input axi_word_t addr, input axi_word_t wdata, input logic [4:0] wreg,
			input logic wd, input axi_word_t exp_result, input logic exp_err);
		int   cycles;
		int   errors_before;
		logic passthrough;
		errors_before = errors;
		passthrough = st ? (f.store.kind == st_none) : (f.load == ld_none);
		@(posedge clk);
		#1;
		is_store_i = st;
		funct_i = f;
		addr_i = addr;
		wdata_i = wdata;
		wreg_i = wreg;
		wd_i = wd;
		req_valid_i = 1'b1;
		@(posedge clk);
		#1;
		req_valid_i = 1'b0;
		cycles = 1;
		while (!done_o && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!done_o) begin
			$display("test %0d: timeout, done_o did not rise within %0d cycles",
				num, TIMEOUT_CYCLES);
			timed_out = 1'b1;
			errors++;
		end else begin
			// passthrough goes idle, address phase, done
			if (passthrough && cycles != 2) begin
				$display("done_o came %0d cycles after the request instead of 2", cycles);
				errors++;
			end
			check_word("result_o", result_o, exp_result);
			check_err(err_o, exp_err);
			// writeback is dropped on an error response
			check_wreg(wreg_o, wd_o, wreg, wd && !exp_err);
		end
		tests++;
		if (errors != errors_before) begin
			failed_tests++;
			$display("test %0d: fail (addr 0x%h)", num, addr);
		end else begin
			$display("test %0d: pass (addr 0x%h)", num, addr);
		end
	endtask

	initial begin
		int          fd;
		int          n;
		int          gap;
		string       line;
		lsu_funct_u  v_funct_u;
		logic [31:0] v_st, v_funct, v_addr, v_wdata, v_wreg, v_wd, v_res, v_err;
		clk = 1'b0;
		rstn = 1'b1;
		req_valid_i = 1'b0;
		is_store_i = 1'b0;
		funct_i = '0;
		addr_i = '0;
		wdata_i = '0;
		wreg_i = '0;
		wd_i = 1'b0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		timed_out = 1'b0;
		void'($urandom(32'h0ce4_3079));
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rstn = 1'b0;
		fd = $fopen("test/lsu_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file test/lsu_vectors.txt");
			errors++;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				line = "";
				void'($fgets(line, fd));
				// comment and blank lines do not scan as eight fields
				n = $sscanf(line, "%h %h %h %h %h %h %h %h",
					v_st, v_funct, v_addr, v_wdata, v_wreg, v_wd, v_res, v_err);
				if (n == 8) begin
					gap = $urandom % 4;
					repeat (gap) @(posedge clk);
					v_funct_u = v_funct[2:0];
					run_vector(tests + 1, v_st[0], v_funct_u, v_addr, v_wdata,
						v_wreg[4:0], v_wd[0], v_res, v_err[0]);
				end
			end
			$fclose(fd);
		end
		$display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0 && !timed_out && tests > 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== test/lsu_vectors.txt ====
# is_store funct addr wdata wreg wd expected_result expected_err, all hex
# funct: load 1 lb, 2 lh, 3 lw, 5 lbu, 6 lhu, or store 1 sb, 2 sh, 3 sw, 0 is passthrough
0 0 12345678 00000000 05 1 12345678 0
0 0 deadbeef 00000000 1f 0 deadbeef 0
1 3 00000010 a5a51234 00 0 00000010 0
0 3 00000010 00000000 03 1 a5a51234 0
1 1 00000021 123456ab 00 0 00000021 0
1 2 00000022 9999cdef 00 0 00000022 0
1 1 00000020 ffffff77 00 0 00000020 0
0 3 00000020 00000000 04 1 cdefab77 0
1 2 00000031 00008642 00 0 00000031 0
0 3 00000030 00000000 06 1 00008642 0
1 3 00000040 8f7fc0e1 00 0 00000040 0
0 1 00000040 00000000 07 1 ffffffe1 0
0 1 00000042 00000000 08 1 0000007f 0
0 1 00000043 00000000 09 1 ffffff8f 0
0 5 00000041 00000000 0a 1 000000c0 0
0 5 00000043 00000000 0b 1 0000008f 0
0 2 00000040 00000000 0c 1 ffffc0e1 0
0 2 00000042 00000000 0d 1 ffff8f7f 0
0 2 00000043 00000000 0e 1 ffff8f7f 0
0 6 00000040 00000000 0f 1 0000c0e1 0
0 6 00000042 00000000 10 1 00008f7f 0
0 3 00000040 00000000 11 1 8f7fc0e1 0
1 3 00000400 11112222 00 1 00000400 1
1 1 00000410 000000ff 00 1 00000410 1
1 3 fffffff0 33334444 00 0 fffffff0 1
0 3 00000400 00000000 12 1 00000000 1
0 1 000007fc 00000000 13 1 00000000 1
0 3 00000000 00000000 14 1 00000000 0
0 3 00000010 00000000 18 1 a5a51234 0
0 3 000003f0 00000000 15 1 00000000 0
1 3 000003fc cafef00d 00 0 000003fc 0
0 6 000003fe 00000000 16 1 0000cafe 0
0 0 0badf00d 00000000 17 1 0badf00d 0
